//--- common/cadr_pkg.sv
// CADR core shared types
`default_nettype none

package cadr_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths with a meaning

   typedef logic [31:0] word_t;         // Datapath word
   typedef logic [32:0] alu_word_t;     // ALU result, carry out on top
   typedef logic [13:0] pc_t;           // Microcode address
   typedef logic [9:0]  amem_addr_t;    // A memory address
   typedef logic [4:0]  mmem_addr_t;    // M memory address
   typedef logic [15:0] spy_word_t;     // Spy data half word
   typedef logic [4:0]  spy_addr_t;     // Spy register number

   ////////////////////////////////////////////////////////////////////////////
   // Encodings

   typedef enum logic [3:0] {
      ALU_SETZ = 4'd0,                  // Zero
      ALU_AND  = 4'd1,
      ALU_OR   = 4'd2,
      ALU_XOR  = 4'd3,
      ALU_ADD  = 4'd4,                  // A + M + cin
      ALU_SUB  = 4'd5,                  // A + ~M + cin
      ALU_SETA = 4'd6,
      ALU_SETM = 4'd7,
      ALU_SETO = 4'd8                   // All ones
   } alu_op_t;

   typedef enum logic [1:0] {
      OB_ALU       = 2'd0,              // Straight through
      OB_ALU_RIGHT = 2'd1,              // Bits 32..1
      OB_ALU_LEFT  = 2'd2               // Bits 30..0, zero in
   } ob_sel_t;

   typedef enum logic [2:0] {
      CYC_RESET  = 3'd0,
      CYC_DECODE = 3'd1,                // Also the halt wait state
      CYC_READ   = 3'd2,
      CYC_ALU    = 3'd3,
      CYC_WRITE  = 3'd4,
      CYC_FETCH  = 3'd5
   } cycle_state_t;

   typedef enum logic [4:0] {
      SPY_IR_LOW  = 5'd0,
      SPY_IR_MID  = 5'd1,
      SPY_IR_HIGH = 5'd2,
      SPY_PC      = 5'd3,
      SPY_OB_LOW  = 5'd4,               // OB words read L
      SPY_OB_HIGH = 5'd5,
      SPY_A_LOW   = 5'd6,
      SPY_A_HIGH  = 5'd7,
      SPY_M_LOW   = 5'd8,               // M words read the M bus
      SPY_M_HIGH  = 5'd9,
      SPY_MD_LOW  = 5'd10,              // Writable
      SPY_MD_HIGH = 5'd11,              // Writable
      SPY_STATUS  = 5'd12               // Halted and idle flags
   } spy_reg_t;

   ////////////////////////////////////////////////////////////////////////////
   // Microinstruction, 49 bits

   typedef struct packed {
      logic [13:0] pad;                 // Unused high bits
      amem_addr_t  a_src;               // A operand address
      mmem_addr_t  m_src;               // M operand address
      logic        m_from_md;           // M bus from MD
      logic        dest_a;              // Write L to A memory
      logic        dest_m;              // Write L to M and A memory
      amem_addr_t  dest_addr;           // Write address
      alu_op_t     alu_op;
      ob_sel_t     ob_sel;
      logic        carry_in;
   } uinst_t;

   // One-hot phase strobes, all low in reset
   typedef struct packed {
      logic decode;
      logic read;
      logic alu;
      logic write;
      logic fetch;
   } cycle_strobes_t;

endpackage

`default_nettype wire

//--- hdl/cycle_sequencer.sv
// Microcycle sequencer
`timescale 1ns/1ns
`default_nettype none

module cycle_sequencer (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       ext_halt,  // Hold in decode
   input  wire                       step,      // Release one instruction
   output cadr_pkg::cycle_strobes_t  strobes,
   output logic                      idle
);

   import cadr_pkg::*;

   cycle_state_t state;
   cycle_state_t state_nxt;
   logic         step_pending;          // Step seen, not yet used
   logic         leave_decode;          // Start of an instruction

   assign leave_decode = (state == CYC_DECODE) && (!ext_halt || step_pending);
   assign idle         = (state == CYC_DECODE) && !step_pending;

   always_comb begin
      case (state)
         CYC_RESET:  state_nxt = CYC_DECODE;
         CYC_DECODE: state_nxt = leave_decode ? CYC_READ : CYC_DECODE;
         CYC_READ:   state_nxt = CYC_ALU;
         CYC_ALU:    state_nxt = CYC_WRITE;
         CYC_WRITE:  state_nxt = CYC_FETCH;
         CYC_FETCH:  state_nxt = CYC_DECODE;
         default:    state_nxt = CYC_RESET;  // Unused codes recover
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= CYC_RESET;
         step_pending <= 1'b0;
      end else begin
         state <= state_nxt;
         if (leave_decode)
            step_pending <= step;       // Consumed, keep a fresh pulse
         else if (step)
            step_pending <= 1'b1;
      end
   end

   // Strobes decoded from state
   always_comb begin
      strobes        = '0;
      strobes.decode = (state == CYC_DECODE);
      strobes.read   = (state == CYC_READ);
      strobes.alu    = (state == CYC_ALU);
      strobes.write  = (state == CYC_WRITE);
      strobes.fetch  = (state == CYC_FETCH);
   end

endmodule

`default_nettype wire

//--- hdl/micro_control.sv
// Instruction register and PC
`timescale 1ns/1ns
`default_nettype none

module micro_control (
   input  wire                       clk,
   input  wire                       reset,
   input  cadr_pkg::cycle_strobes_t  strobes,
   input  cadr_pkg::uinst_t          mcr_data_in,  // Word at the PC
   output cadr_pkg::uinst_t          ir,
   output cadr_pkg::pc_t             pc
);

   ////////////////////////////////////////////////////////////////////////////
   // IREG
   //
   // The microcode port answers the PC combinationally. The word is taken
   // only at the end of fetch, so the instruction executed by a step is
   // the one addressed by the previous step.

   always_ff @(posedge clk) begin
      if (reset)
         ir <= '0;                      // All zero IR writes nothing
      else if (strobes.fetch)
         ir <= mcr_data_in;
   end

   ////////////////////////////////////////////////////////////////////////////
   // NPC
   //
   // No jumps or dispatch, so the next PC is always PC + 1

   always_ff @(posedge clk) begin
      if (reset)
         pc <= '0;
      else if (strobes.fetch)
         pc <= pc + 1'b1;               // Wraps at the top of microcode
   end

endmodule

`default_nettype wire

//--- hdl/spy_port.sv
// Spy debug port
`timescale 1ns/1ns
`default_nettype none

module spy_port (
   input  wire                  clk,
   input  wire                  reset,
   input  cadr_pkg::spy_addr_t  eadr,      // Register number
   input  wire                  dbread,    // Read level
   input  wire                  dbwrite,   // Write level
   input  cadr_pkg::spy_word_t  spy_in,
   input  cadr_pkg::uinst_t     ir,
   input  cadr_pkg::pc_t        pc,
   input  cadr_pkg::word_t      l_reg,     // Shown as OB
   input  cadr_pkg::word_t      a_bus,
   input  cadr_pkg::word_t      m_bus,
   input  wire                  idle,
   input  wire                  ext_halt,
   output cadr_pkg::word_t      md,
   output cadr_pkg::spy_word_t  spy_out
);

   import cadr_pkg::*;

   spy_reg_t    sel;                    // Decoded register number
   logic [48:0] ir_bits;                // Flat view of the IR
   spy_word_t   spy_mux;                // Selected half word

   assign sel     = spy_reg_t'(eadr);
   assign ir_bits = ir;

   ////////////////////////////////////////////////////////////////////////////
   // Read select

   always_comb begin
      case (sel)
         SPY_IR_LOW:  spy_mux = ir_bits[15:0];
         SPY_IR_MID:  spy_mux = ir_bits[31:16];
         SPY_IR_HIGH: spy_mux = ir_bits[47:32];    // Bit 48 is pad
         SPY_PC:      spy_mux = spy_word_t'(pc);   // Zero extended
         SPY_OB_LOW:  spy_mux = l_reg[15:0];
         SPY_OB_HIGH: spy_mux = l_reg[31:16];
         SPY_A_LOW:   spy_mux = a_bus[15:0];
         SPY_A_HIGH:  spy_mux = a_bus[31:16];
         SPY_M_LOW:   spy_mux = m_bus[15:0];
         SPY_M_HIGH:  spy_mux = m_bus[31:16];
         SPY_MD_LOW:  spy_mux = md[15:0];
         SPY_MD_HIGH: spy_mux = md[31:16];
         SPY_STATUS:  spy_mux = {14'd0, idle, ext_halt};
         default:     spy_mux = '0;        // Unknown numbers read zero
      endcase
   end

   // One clock read latency, holds while dbread is low
   always_ff @(posedge clk) begin
      if (reset)
         spy_out <= '0;
      else if (dbread)
         spy_out <= spy_mux;
   end

   ////////////////////////////////////////////////////////////////////////////
   // MD register, loaded one half at a time

   always_ff @(posedge clk) begin
      if (reset) begin
         md <= '0;
      end else if (dbwrite) begin
         if (sel == SPY_MD_LOW)
            md[15:0] <= spy_in;
         if (sel == SPY_MD_HIGH)
            md[31:16] <= spy_in;
      end
   end

endmodule

`default_nettype wire

//--- datapath/scratch_memories.sv
// A and M scratch memories
`timescale 1ns/1ns
`default_nettype none

module scratch_memories #(
   parameter int AMEM_DEPTH = 1024      // A memory words, at most 1024
) (
   input  wire                       clk,
   input  cadr_pkg::cycle_strobes_t  strobes,
   input  cadr_pkg::uinst_t          ir,
   input  cadr_pkg::word_t           l_reg,   // Writeback data
   output cadr_pkg::word_t           a_bus,   // A read latch
   output cadr_pkg::word_t           m_mem    // M read latch
);

   import cadr_pkg::*;

   localparam int AW = $clog2(AMEM_DEPTH);    // A index bits used

   word_t          amem [AMEM_DEPTH];
   word_t          mmem [32];
   logic [AW-1:0]  a_rd_idx;            // Upper address bits dropped
   logic [AW-1:0]  a_wr_idx;
   mmem_addr_t     m_wr_idx;
   logic           a_we;
   logic           m_we;

   ////////////////////////////////////////////////////////////////////////////
   // Address and enable decode

   assign a_rd_idx = ir.a_src[AW-1:0];
   assign a_wr_idx = ir.dest_addr[AW-1:0];
   assign m_wr_idx = ir.dest_addr[4:0];      // Low bits pick the M word

   // M destinations land in A memory as well
   assign a_we = strobes.write && (ir.dest_a || ir.dest_m);
   assign m_we = strobes.write && ir.dest_m;

   ////////////////////////////////////////////////////////////////////////////
   // AMEM

   always_ff @(posedge clk) begin
      if (a_we)
         amem[a_wr_idx] <= l_reg;
   end

   // Read at end of decode, held through the instruction
   always_ff @(posedge clk) begin
      if (strobes.decode)
         a_bus <= amem[a_rd_idx];
   end

   ////////////////////////////////////////////////////////////////////////////
   // MMEM

   always_ff @(posedge clk) begin
      if (m_we)
         mmem[m_wr_idx] <= l_reg;
   end

   always_ff @(posedge clk) begin
      if (strobes.decode)
         m_mem <= mmem[ir.m_src];
   end

   // Writes happen at write, the next decode re-reads them, so an
   // instruction sees its predecessor's result with no bypass path

endmodule

`default_nettype wire

//--- datapath/alu_unit.sv
// ALU, output select and L register
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
   input  wire                       clk,
   input  wire                       reset,
   input  cadr_pkg::cycle_strobes_t  strobes,
   input  cadr_pkg::uinst_t          ir,
   input  cadr_pkg::word_t           a_bus,   // A operand
   input  cadr_pkg::word_t           m_mem,   // M memory latch
   input  cadr_pkg::word_t           md,      // Spy loaded MD
   output cadr_pkg::word_t           m_bus,   // Selected M operand
   output cadr_pkg::word_t           l_reg
);

   import cadr_pkg::*;

   alu_word_t alu;                      // Result with carry out
   alu_word_t a_ext;                    // A with a zero top bit
   alu_word_t m_ext;                    // M with a zero top bit
   alu_word_t m_inv;                    // Complemented M for subtract
   alu_word_t cin_ext;                  // Carry in as a word
   word_t     ob;                       // Output bus

   ////////////////////////////////////////////////////////////////////////////
   // M bus select

   assign m_bus = ir.m_from_md ? md : m_mem;

   ////////////////////////////////////////////////////////////////////////////
   // ALU

   assign a_ext   = {1'b0, a_bus};
   assign m_ext   = {1'b0, m_bus};
   assign m_inv   = {1'b0, ~m_bus};
   assign cin_ext = alu_word_t'(ir.carry_in);

   always_comb begin
      case (ir.alu_op)
         ALU_SETZ: alu = '0;
         ALU_AND:  alu = a_ext & m_ext;
         ALU_OR:   alu = a_ext | m_ext;
         ALU_XOR:  alu = a_ext ^ m_ext;
         ALU_ADD:  alu = a_ext + m_ext + cin_ext;
         ALU_SUB:  alu = a_ext + m_inv + cin_ext;  // A - M when cin set
         ALU_SETA: alu = a_ext;
         ALU_SETM: alu = m_ext;
         ALU_SETO: alu = {1'b0, {32{1'b1}}};
         default:  alu = '0;            // Undefined ops act as SETZ
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output bus select

   always_comb begin
      case (ir.ob_sel)
         OB_ALU_RIGHT: ob = alu[32:1];              // Carry shifts in on top
         OB_ALU_LEFT:  ob = {alu[30:0], 1'b0};      // Zero shifts in
         default:      ob = alu[31:0];              // Code 3 too
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // L register

   // Loaded at end of alu, feeds writeback in the write state
   always_ff @(posedge clk) begin
      if (reset)
         l_reg <= '0;
      else if (strobes.alu)
         l_reg <= ob;
   end

endmodule

`default_nettype wire

//--- hdl/cadr_core.sv
// CADR microcycle core
`timescale 1ns/1ns
`default_nettype none

module cadr_core #(
   parameter int AMEM_DEPTH = 1024      // A memory words
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  ext_halt,     // Run control level
   input  wire                  step,         // Single step pulse
   input  wire [4:0]            eadr,         // Spy register number
   input  wire                  dbread,
   input  wire                  dbwrite,
   input  wire [15:0]           spy_in,
   input  cadr_pkg::uinst_t     mcr_data_in,  // Microcode word
   output cadr_pkg::pc_t        mcr_addr,     // Microcode address, the PC
   output cadr_pkg::spy_word_t  spy_out
);

   import cadr_pkg::*;

   cycle_strobes_t strobes;             // Phase strobes to all blocks
   logic           idle;                // Waiting in decode, no step
   uinst_t         ir;                  // Current microinstruction
   word_t          a_bus;               // A read latch
   word_t          m_mem;               // M read latch
   word_t          m_bus;               // Selected M operand
   word_t          l_reg;               // Latched output bus
   word_t          md;                  // Spy loaded MD

   ////////////////////////////////////////////////////////////////////////////
   // Control

   cycle_sequencer sequencer_i (
      .clk      (clk),
      .reset    (reset),
      .ext_halt (ext_halt),
      .step     (step),
      .strobes  (strobes),
      .idle     (idle)
   );

   micro_control control_i (
      .clk         (clk),
      .reset       (reset),
      .strobes     (strobes),
      .mcr_data_in (mcr_data_in),
      .ir          (ir),
      .pc          (mcr_addr)           // PC goes straight out
   );

   ////////////////////////////////////////////////////////////////////////////
   // Datapath

   scratch_memories #(
      .AMEM_DEPTH (AMEM_DEPTH)
   ) memories_i (
      .clk     (clk),
      .strobes (strobes),
      .ir      (ir),
      .l_reg   (l_reg),
      .a_bus   (a_bus),
      .m_mem   (m_mem)
   );

   alu_unit alu_i (
      .clk     (clk),
      .reset   (reset),
      .strobes (strobes),
      .ir      (ir),
      .a_bus   (a_bus),
      .m_mem   (m_mem),
      .md      (md),
      .m_bus   (m_bus),
      .l_reg   (l_reg)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Debug

   spy_port spy_i (
      .clk      (clk),
      .reset    (reset),
      .eadr     (eadr),
      .dbread   (dbread),
      .dbwrite  (dbwrite),
      .spy_in   (spy_in),
      .ir       (ir),
      .pc       (mcr_addr),
      .l_reg    (l_reg),
      .a_bus    (a_bus),
      .m_bus    (m_bus),
      .idle     (idle),
      .ext_halt (ext_halt),
      .md       (md),
      .spy_out  (spy_out)
   );

endmodule

`default_nettype wire

//--- verification/cadr_core_tb.sv
// CADR core testbench
`timescale 1ns/1ns
`default_nettype none

module cadr_core_tb;

   import cadr_pkg::*;

   typedef struct packed {
      word_t      md;                   // MD loaded before the step
      uinst_t     ui;                   // Instruction run by the step
      logic [2:0] chk;                  // 0 OB, 1 A and M, 2 MD
   } row_t;

   logic      clk;
   logic      reset;
   logic      ext_halt;
   logic      step;
   logic [4:0]  eadr;
   logic      dbread;
   logic      dbwrite;
   logic [15:0] spy_in;
   uinst_t    mcr_data_in;
   pc_t       mcr_addr;
   spy_word_t spy_out;

   uinst_t    ucode [256];              // Microcode memory model
   row_t      rows [$];
   word_t     amodel [1024];            // Reference A memory
   logic      avalid [1024];
   word_t     mmodel [32];              // Reference M memory
   logic      mvalid [32];
   word_t     md_model;
   word_t     l_model;
   pc_t       exp_pc;
   integer    seed = 58210;
   int        test_errs = 0;
   int        n_pass = 0;
   int        n_fail = 0;
   int        i;
   logic      ok;
   word_t     v;
   row_t      row;
   uinst_t    next_ui;

   assign mcr_data_in = (mcr_addr < 14'd256) ? ucode[mcr_addr[7:0]] : '0;

   cadr_core #(.AMEM_DEPTH(1024)) dut_i (
      .clk(clk), .reset(reset), .ext_halt(ext_halt), .step(step),
      .eadr(eadr), .dbread(dbread), .dbwrite(dbwrite), .spy_in(spy_in),
      .mcr_data_in(mcr_data_in), .mcr_addr(mcr_addr), .spy_out(spy_out)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;           // 40 ns period
   end

   initial begin
      int limit;
      #1;
      limit = rows.size() * 60 * 40;    // Cycles per row times period
      #(limit);
      $display("timeout: the run did not finish within %0d ns", limit);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus helpers

   task automatic tick();
      @(posedge clk);
      #5;                               // Drive after the edge
   endtask

   task automatic spy_read(input spy_addr_t r, output spy_word_t d);
      eadr   = r;
      dbread = 1'b1;
      tick();
      dbread = 1'b0;
      d      = spy_out;                 // One clock latency
   endtask

   task automatic spy_write(input spy_addr_t r, input spy_word_t d);
      eadr    = r;
      spy_in  = d;
      dbwrite = 1'b1;
      tick();
      dbwrite = 1'b0;
   endtask

   task automatic check_spy(input spy_addr_t r, input string name, input spy_word_t exp);
      spy_word_t got;
      spy_read(r, got);
      if (got !== exp) begin
         $display("FAIL %s: got %h expected %h", name, got, exp);
         test_errs++;
      end
   endtask

   // Pulse step, then poll status until idle
   task automatic do_step(output logic done);
      spy_word_t st;
      int        polls;
      done = 1'b0;
      step = 1'b1;
      tick();
      step = 1'b0;
      for (polls = 0; polls < 20 && !done; polls++) begin
         spy_read(SPY_STATUS, st);
         if (st[1])
            done = 1'b1;
      end
   endtask

   task automatic end_test(input string name);
      if (test_errs == 0) begin
         $display("test %s: passed", name);
         n_pass++;
      end else begin
         $display("test %s: failed with %0d errors", name, test_errs);
         n_fail++;
      end
      test_errs = 0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model

   function automatic uinst_t make_ui(input amem_addr_t a_src, input mmem_addr_t m_src,
                                      input logic from_md, input logic da, input logic dm,
                                      input amem_addr_t dst, input logic [3:0] op,
                                      input logic [1:0] ob, input logic cin);
      uinst_t u;
      u           = '0;
      u.a_src     = a_src;
      u.m_src     = m_src;
      u.m_from_md = from_md;
      u.dest_a    = da;
      u.dest_m    = dm;
      u.dest_addr = dst;
      u.alu_op    = alu_op_t'(op);
      u.ob_sel    = ob_sel_t'(ob);
      u.carry_in  = cin;
      return u;
   endfunction

   function automatic logic [32:0] alu_expect(input logic [3:0] op, input word_t a,
                                              input word_t m, input logic cin);
      logic [32:0] wa;
      logic [32:0] wm;
      wa = {1'b0, a};
      wm = {1'b0, m};
      case (op)
         4'd1:    return {1'b0, a & m};
         4'd2:    return {1'b0, a | m};
         4'd3:    return {1'b0, a ^ m};
         4'd4:    return wa + wm + cin;
         4'd5:    return wa + (33'h0_FFFF_FFFF - wm) + cin;  // Ones complement of M
         4'd6:    return wa;
         4'd7:    return wm;
         4'd8:    return 33'h0_FFFF_FFFF;
         default: return '0;
      endcase
   endfunction

   function automatic word_t ob_expect(input logic [1:0] sel, input logic [32:0] r);
      case (sel)
         2'd1:    return word_t'(r >> 1);   // Carry lands in bit 31
         2'd2:    return r[31:0] << 1;
         default: return r[31:0];
      endcase
   endfunction

   task automatic run_model(input uinst_t u);
      word_t a;
      word_t m;
      a       = amodel[u.a_src];
      m       = u.m_from_md ? md_model : mmodel[u.m_src];
      l_model = ob_expect(u.ob_sel, alu_expect(u.alu_op, a, m, u.carry_in));
      if (u.dest_a || u.dest_m) begin
         amodel[u.dest_addr] = l_model;
         avalid[u.dest_addr] = 1'b1;
      end
      if (u.dest_m) begin
         mmodel[u.dest_addr[4:0]] = l_model;
         mvalid[u.dest_addr[4:0]] = 1'b1;
      end
   endtask

   task automatic add_row(input word_t md, input uinst_t u, input logic [2:0] chk);
      row_t r;
      r.md  = md;
      r.ui  = u;
      r.chk = chk;
      rows.push_back(r);
   endtask

   // Loads memories, then every op with MD as M, then shifts and writeback
   task automatic build_table();
      int op;
      int cin;
      add_row($random(seed) | 32'h8000_0000, make_ui(0, 0, 1, 0, 1, 5, 7, 0, 0), 3'b101);
      add_row($random(seed), make_ui(0, 0, 1, 0, 1, 10, 7, 0, 0), 3'b001);
      add_row($random(seed), make_ui(0, 0, 1, 1, 0, 37, 7, 0, 0), 3'b011);  // A only
      add_row($random(seed), make_ui(37, 5, 0, 0, 0, 0, 6, 0, 0), 3'b011);
      add_row($random(seed), make_ui(10, 10, 0, 0, 0, 0, 3, 0, 0), 3'b011);
      for (op = 0; op < 10; op++) begin
         for (cin = 0; cin < 2; cin++)
            add_row($random(seed), make_ui(5, 0, 1, 0, 0, 0, (op == 9) ? 12 : op, 0, cin),
                    3'b111);
      end
      add_row($random(seed) | 32'hC000_0000, make_ui(5, 0, 1, 0, 0, 0, 4, 1, 1), 3'b011);
      add_row($random(seed) | 32'hC000_0000, make_ui(5, 0, 1, 0, 0, 0, 4, 2, 0), 3'b011);
      add_row($random(seed), make_ui(5, 0, 1, 0, 0, 0, 8, 1, 0), 3'b011);
      add_row($random(seed), make_ui(5, 0, 1, 0, 0, 0, 5, 3, 1), 3'b011);  // Code 3
      add_row($random(seed), make_ui(5, 0, 1, 0, 1, 20, 4, 0, 0), 3'b011);
      add_row($random(seed), make_ui(20, 20, 0, 0, 0, 0, 6, 0, 0), 3'b011);
      add_row($random(seed), make_ui(20, 20, 0, 1, 0, 21, 5, 0, 1), 3'b011);
   endtask

   task automatic check_ir(input uinst_t u);
      logic [48:0] bits;
      bits = u;
      check_spy(SPY_IR_LOW, "ir_low", bits[15:0]);
      check_spy(SPY_IR_MID, "ir_mid", bits[31:16]);
      check_spy(SPY_IR_HIGH, "ir_high", bits[47:32]);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      reset    = 1'b1;
      ext_halt = 1'b1;                  // Held so nothing runs on its own
      step     = 1'b0;
      eadr     = '0;
      dbread   = 1'b0;
      dbwrite  = 1'b0;
      spy_in   = '0;
      for (i = 0; i < 1024; i++)
         avalid[i] = 1'b0;
      for (i = 0; i < 32; i++)
         mvalid[i] = 1'b0;
      build_table();
      for (i = 0; i < 256; i++)
         ucode[i] = (i < rows.size()) ? rows[i].ui : '0;
      repeat (3) @(posedge clk);
      #5;
      reset = 1'b0;
      tick();

      check_spy(SPY_PC, "pc", 16'h0000);
      check_ir('0);
      check_spy(SPY_OB_LOW, "ob_low", 16'h0000);
      check_spy(SPY_OB_HIGH, "ob_high", 16'h0000);
      check_spy(SPY_MD_LOW, "md_low", 16'h0000);
      check_spy(SPY_MD_HIGH, "md_high", 16'h0000);
      check_spy(SPY_STATUS, "status", 16'h0003);  // Halted and idle
      end_test("reset values");

      v = $random(seed);
      spy_write(SPY_MD_LOW, v[15:0]);
      spy_write(SPY_MD_HIGH, v[31:16]);
      spy_write(SPY_PC, ~v[15:0]);      // Read only number
      spy_write(5'd20, ~v[31:16]);      // Unused number
      md_model = v;
      check_spy(SPY_MD_LOW, "md_low", v[15:0]);
      check_spy(SPY_MD_HIGH, "md_high", v[31:16]);
      check_spy(SPY_PC, "pc", 16'h0000);
      end_test("md spy access");

      // First step runs the zero IR and fetches word 0
      do_step(ok);
      if (!ok) begin
         $display("first step: core did not return to idle");
         test_errs++;
      end
      exp_pc  = 14'd1;
      l_model = '0;
      check_spy(SPY_PC, "pc", {2'b00, exp_pc});
      check_ir(rows[0].ui);
      check_spy(SPY_OB_LOW, "ob_low", 16'h0000);
      end_test("first step");

      for (i = 0; i < rows.size(); i++) begin
         row     = rows[i];
         next_ui = (i + 1 < rows.size()) ? rows[i + 1].ui : '0;
         spy_write(SPY_MD_LOW, row.md[15:0]);
         spy_write(SPY_MD_HIGH, row.md[31:16]);
         md_model = row.md;
         run_model(row.ui);
         do_step(ok);
         if (!ok) begin
            $display("row %0d: core did not return to idle after a step", i);
            test_errs++;
         end
         exp_pc++;
         check_spy(SPY_PC, "pc", {2'b00, exp_pc});
         check_ir(next_ui);             // Next word already fetched
         if (row.chk[0]) begin
            check_spy(SPY_OB_LOW, "ob_low", l_model[15:0]);
            check_spy(SPY_OB_HIGH, "ob_high", l_model[31:16]);
         end
         if (row.chk[1]) begin
            if (avalid[next_ui.a_src]) begin
               check_spy(SPY_A_LOW, "a_low", amodel[next_ui.a_src][15:0]);
               check_spy(SPY_A_HIGH, "a_high", amodel[next_ui.a_src][31:16]);
            end
            if (next_ui.m_from_md) begin
               check_spy(SPY_M_LOW, "m_low", md_model[15:0]);
               check_spy(SPY_M_HIGH, "m_high", md_model[31:16]);
            end else if (mvalid[next_ui.m_src]) begin
               check_spy(SPY_M_LOW, "m_low", mmodel[next_ui.m_src][15:0]);
               check_spy(SPY_M_HIGH, "m_high", mmodel[next_ui.m_src][31:16]);
            end
         end
         if (row.chk[2]) begin
            check_spy(SPY_MD_LOW, "md_low", md_model[15:0]);
            check_spy(SPY_MD_HIGH, "md_high", md_model[31:16]);
         end
         end_test($sformatf("row %0d", i));
      end

      // Free run, one PC step per 5 clocks
      ext_halt = 1'b0;
      for (i = 1; i <= 4; i++) begin
         repeat (5) tick();
         if (mcr_addr !== exp_pc + pc_t'(i)) begin
            $display("FAIL mcr_addr: got %h expected %h", mcr_addr, exp_pc + pc_t'(i));
            test_errs++;
         end
      end
      ext_halt = 1'b1;                  // Caught at decode
      exp_pc   = exp_pc + 14'd4;
      repeat (10) tick();
      check_spy(SPY_PC, "pc", {2'b00, exp_pc});
      check_spy(SPY_STATUS, "status", 16'h0003);
      end_test("free run and halt");

      $display("tests passed %0d failed %0d", n_pass, n_fail);
      if (n_fail == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- cadr_core.f
common/cadr_pkg.sv
hdl/cycle_sequencer.sv
hdl/micro_control.sv
hdl/spy_port.sv
datapath/scratch_memories.sv
datapath/alu_unit.sv
hdl/cadr_core.sv
verification/cadr_core_tb.sv
